// File: rtl/tpl_adc_pkg.sv
// JESD204 ADC transport layer, shared definitions
// sizes, register map, PN and state enums and the bus structs used by
// the register blocks, the PN monitors and the data formatters

`default_nettype none

package tpl_adc_pkg;

  // ************************************************************
  // data path sizes
  localparam int num_channels   = 2;
  localparam int sample_width   = 16;
  localparam int converter_bits = 14;
  localparam int sign_bit       = converter_bits - 1;
  localparam int clk_ratio      = 1;

  localparam logic [31:0] core_version = 32'h0001_0061;

  // ************************************************************
  // register word addresses
  localparam logic [7:0] reg_version   = 8'h00;
  localparam logic [7:0] reg_scratch   = 8'h02;
  localparam logic [7:0] reg_status    = 8'h10;
  localparam logic [7:0] reg_clk_ratio = 8'h11;

  localparam logic [7:0] chan_base   = 8'h40;
  localparam logic [7:0] chan_stride = 8'h10;

  // offsets inside one channel window
  localparam logic [7:0] chan_ctrl   = 8'h00;
  localparam logic [7:0] chan_status = 8'h01;
  localparam logic [7:0] chan_pn_sel = 8'h02;

  // PN monitor thresholds, in consecutive valid samples
  localparam int pn_cnt_w       = 4;
  localparam int pn_loss_count  = 4;
  localparam int pn_sync_count  = 16;

  // ************************************************************
  // types
  typedef enum logic {
    pn7  = 1'b0,
    pn15 = 1'b1
  } pn_seq_e;

  typedef enum logic {
    in_sync     = 1'b0,
    out_of_sync = 1'b1
  } pn_state_e;

  typedef struct packed {
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } reg_rsp_t;

  // rdata stays zero unless ack is set, so answers can be ORed
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } blk_rsp_t;

  typedef struct packed {
    logic    enable;
    logic    dfmt_enable;
    logic    dfmt_type;
    logic    sign_extend;
    pn_seq_e pn_sel;
  } chan_cfg_t;

  typedef logic [num_channels-1:0][sample_width-1:0] adc_beat_t;

endpackage

`default_nettype wire

// File: rtl/tpl_adc_regmap_common.sv
// Common register block of the ADC transport layer
// version, scratch, status and clock ratio registers; keeps the
// sticky overflow flag and the ORed channel status bits

`default_nettype none

module tpl_adc_regmap_common import tpl_adc_pkg::*; (
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    strobe,
  input  reg_req_t                req,
  input  logic [num_channels-1:0] chan_pn_err,
  input  logic [num_channels-1:0] chan_pn_oos,
  input  logic                    adc_dovf,
  output blk_rsp_t                rsp
);

  logic [31:0] scratch;
  logic        status_pn_err;
  logic        status_pn_oos;
  logic        ovf_sticky;
  logic        hit;
  logic [31:0] rdata_nxt;
  logic        wr_scratch;
  logic        wr_status;

  // address decode, read mux
  always_comb begin
    hit = 1'b1;
    rdata_nxt = '0;
    case (req.addr)
      reg_version:   rdata_nxt = core_version;
      reg_scratch:   rdata_nxt = scratch;
      reg_status:    rdata_nxt = {29'd0, ovf_sticky, status_pn_oos, status_pn_err};
      reg_clk_ratio: rdata_nxt = 32'(clk_ratio);
      default:       hit = 1'b0;
    endcase
  end

  assign wr_scratch = strobe && req.write && (req.addr == reg_scratch);
  assign wr_status  = strobe && req.write && (req.addr == reg_status);

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      scratch       <= '0;
      status_pn_err <= 1'b0;
      status_pn_oos <= 1'b0;
      ovf_sticky    <= 1'b0;
      rsp           <= '0;
    end else begin
      // channel flags, one cycle behind
      status_pn_err <= |chan_pn_err;
      status_pn_oos <= |chan_pn_oos;
      if (wr_scratch) begin
        scratch <= req.wdata;
      end
      // a new overflow beats the clear
      if (adc_dovf) begin
        ovf_sticky <= 1'b1;
      end else if (wr_status && req.wdata[2]) begin
        ovf_sticky <= 1'b0;
      end
      rsp.ack   <= strobe && hit;
      rsp.rdata <= (strobe && hit) ? rdata_nxt : '0;
    end
  end

  ack_after_strobe: assert property (@(posedge link_clk) disable iff (adc_rst)
    rsp.ack |-> $past(strobe));

endmodule

`default_nettype wire

// File: rtl/tpl_adc_regmap_channel.sv
// Per-channel register block of the ADC transport layer
// holds enable, data format and PN select settings, and the sticky
// PN error flag; status reads return the live out-of-sync flag

`default_nettype none

module tpl_adc_regmap_channel import tpl_adc_pkg::*; (
  input  logic      link_clk,
  input  logic      adc_rst,
  input  logic      strobe,
  input  reg_req_t  req,
  input  logic      chan_index,
  input  logic      pn_err,
  input  logic      pn_oos,
  output chan_cfg_t cfg,
  output logic      err_sticky,
  output blk_rsp_t  rsp
);

  logic [7:0]  win_base;
  logic [7:0]  rel_addr;
  logic        hit;
  logic [31:0] rdata_nxt;
  logic        wr_ctrl;
  logic        wr_status;
  logic        wr_pn_sel;

  // each channel owns one window of chan_stride words
  assign win_base = chan_base + (chan_index ? chan_stride : 8'h00);
  assign rel_addr = req.addr - win_base;

  always_comb begin
    hit = 1'b1;
    rdata_nxt = '0;
    case (rel_addr)
      chan_ctrl: begin
        rdata_nxt = {28'd0, cfg.dfmt_enable, cfg.sign_extend, cfg.dfmt_type, cfg.enable};
      end
      chan_status: begin
        rdata_nxt = {29'd0, pn_oos, err_sticky, 1'b0};
      end
      chan_pn_sel: begin
        rdata_nxt = {31'd0, cfg.pn_sel};
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  assign wr_ctrl   = strobe && req.write && (rel_addr == chan_ctrl);
  assign wr_status = strobe && req.write && (rel_addr == chan_status);
  assign wr_pn_sel = strobe && req.write && (rel_addr == chan_pn_sel);

  // ************************************************************
  // control registers
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      cfg <= '0;
    end else begin
      if (wr_ctrl) begin
        cfg.enable      <= req.wdata[0];
        cfg.dfmt_type   <= req.wdata[1];
        cfg.sign_extend <= req.wdata[2];
        cfg.dfmt_enable <= req.wdata[3];
      end
      if (wr_pn_sel) begin
        cfg.pn_sel <= pn_seq_e'(req.wdata[0]);
      end
    end
  end

  // sticky error and block answer
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      err_sticky <= 1'b0;
      rsp        <= '0;
    end else begin
      // pn_err wins over a clear in the same cycle
      if (pn_err) begin
        err_sticky <= 1'b1;
      end else if (wr_status && req.wdata[1]) begin
        err_sticky <= 1'b0;
      end
      rsp.ack   <= strobe && hit;
      rsp.rdata <= (strobe && hit) ? rdata_nxt : '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/tpl_adc_regmap.sv
// Register map of the ADC transport layer
// accepts one request at a time, strobes the common and channel blocks,
// merges their answers and holds the response until it is taken

`default_nettype none

module tpl_adc_regmap import tpl_adc_pkg::*; (
  input  logic                         link_clk,
  input  logic                         adc_rst,
  input  logic                         req_valid,
  output logic                         req_ready,
  input  reg_req_t                     req,
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output reg_rsp_t                     rsp,
  input  logic [num_channels-1:0]      pn_err,
  input  logic [num_channels-1:0]      pn_oos,
  input  logic                         adc_dovf,
  output chan_cfg_t [num_channels-1:0] cfg
);

  logic                        busy;
  logic                        accept;
  logic                        strobe;
  logic                        wait_rsp;
  reg_req_t                    req_q;
  blk_rsp_t                    common_rsp;
  blk_rsp_t [num_channels-1:0] chan_rsp;
  logic [num_channels-1:0]     err_sticky;
  logic [num_channels:0]       ack_vec;
  logic [31:0]                 rdata_or;

  assign req_ready = ~busy;
  assign accept    = req_valid && req_ready;

  // ************************************************************
  // transaction sequencing
  // accept -> strobe -> block answer -> rsp_valid
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      busy      <= 1'b0;
      strobe    <= 1'b0;
      wait_rsp  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      strobe   <= accept;
      wait_rsp <= strobe;
      if (accept) begin
        busy <= 1'b1;
      end else if (rsp_valid && rsp_ready) begin
        busy <= 1'b0;
      end
      if (wait_rsp) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (accept) begin
      req_q <= req;
    end
    if (wait_rsp) begin
      rsp.rdata <= rdata_or;
      rsp.err   <= ~|ack_vec;
    end
  end

  // merge block answers
  always_comb begin
    ack_vec[0] = common_rsp.ack;
    rdata_or   = common_rsp.rdata;
    for (int n = 0; n < num_channels; n++) begin
      ack_vec[n+1] = chan_rsp[n].ack;
      rdata_or     = rdata_or | chan_rsp[n].rdata;
    end
  end

  // ************************************************************
  // register blocks
  tpl_adc_regmap_common i_common (
    .link_clk    (link_clk),
    .adc_rst     (adc_rst),
    .strobe      (strobe),
    .req         (req_q),
    .chan_pn_err (err_sticky),
    .chan_pn_oos (pn_oos),
    .adc_dovf    (adc_dovf),
    .rsp         (common_rsp)
  );

  for (genvar i = 0; i < num_channels; i++) begin : g_channel
    tpl_adc_regmap_channel i_channel (
      .link_clk   (link_clk),
      .adc_rst    (adc_rst),
      .strobe     (strobe),
      .req        (req_q),
      .chan_index (1'(i)),
      .pn_err     (pn_err[i]),
      .pn_oos     (pn_oos[i]),
      .cfg        (cfg[i]),
      .err_sticky (err_sticky[i]),
      .rsp        (chan_rsp[i])
    );
  end

  one_ack: assert property (@(posedge link_clk) disable iff (adc_rst)
    $onehot0(ack_vec));

  rsp_hold: assert property (@(posedge link_clk) disable iff (adc_rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// File: rtl/tpl_adc_pn_monitor.sv
// PN sequence monitor, one per channel
// predicts each sample from the previous one with the PN7 or PN15 LFSR
// and tracks sync with consecutive match and mismatch counts

`default_nettype none

module tpl_adc_pn_monitor import tpl_adc_pkg::*; (
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    valid,
  input  logic [sample_width-1:0] sample,
  input  pn_seq_e                 pn_sel,
  output logic                    pn_err,
  output logic                    pn_oos
);

  logic [sample_width-1:0] prev_sample;
  logic [sample_width-1:0] predicted;
  logic                    mismatch;
  pn_state_e               state;
  pn_state_e               state_nxt;
  logic [pn_cnt_w-1:0]     match_cnt;
  logic [pn_cnt_w-1:0]     miss_cnt;

  // bit 0 holds the newest sequence bit; each step shifts in
  // b[n] = b[n-7]^b[n-6] for pn7, b[n-15]^b[n-14] for pn15
  function automatic logic [sample_width-1:0] pn_advance(
    input logic [sample_width-1:0] s,
    input pn_seq_e                 sel
  );
    logic [sample_width-1:0] w;
    logic                    fb;
    w = s;
    for (int k = 0; k < sample_width; k++) begin
      fb = (sel == pn15) ? (w[14] ^ w[13]) : (w[6] ^ w[5]);
      w  = {w[sample_width-2:0], fb};
    end
    return w;
  endfunction

  assign predicted = pn_advance(prev_sample, pn_sel);
  assign mismatch  = (sample != predicted);
  assign pn_oos    = (state == out_of_sync);

  always_comb begin
    state_nxt = state;
    case (state)
      in_sync: begin
        if (valid && mismatch && (miss_cnt == pn_cnt_w'(pn_loss_count - 1))) begin
          state_nxt = out_of_sync;
        end
      end
      default: begin
        if (valid && !mismatch && (match_cnt == pn_cnt_w'(pn_sync_count - 1))) begin
          state_nxt = in_sync;
        end
      end
    endcase
  end

  // ************************************************************
  // state and counters
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      state     <= out_of_sync;
      match_cnt <= '0;
      miss_cnt  <= '0;
      pn_err    <= 1'b0;
    end else begin
      // errors only reported while staying in sync
      pn_err <= valid && mismatch && (state == in_sync) && (state_nxt == in_sync);
      if (valid) begin
        state <= state_nxt;
        if (mismatch) begin
          match_cnt <= '0;
          miss_cnt  <= (state_nxt == in_sync) ? miss_cnt + 1'b1 : '0;
        end else begin
          miss_cnt  <= '0;
          match_cnt <= (state_nxt == out_of_sync) ? match_cnt + 1'b1 : '0;
        end
      end
    end
  end

  // seed for the next prediction
  always_ff @(posedge link_clk) begin
    if (valid) begin
      prev_sample <= sample;
    end
  end

  no_err_oos: assert property (@(posedge link_clk) disable iff (adc_rst)
    pn_err |-> (state == in_sync));

endmodule

`default_nettype wire

// File: rtl/tpl_adc_data_format.sv
// Data format converter, one per channel
// optional offset binary to two's complement and sign extension of the
// converter bits into the sample container, one register stage

`default_nettype none

module tpl_adc_data_format import tpl_adc_pkg::*; (
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    valid,
  input  logic [sample_width-1:0] sample,
  input  chan_cfg_t               cfg,
  output logic                    out_valid,
  output logic [sample_width-1:0] out_sample
);

  logic [sample_width-1:0] fmt;

  always_comb begin
    fmt = sample;
    if (cfg.dfmt_enable) begin
      // inverting the msb turns offset binary into two's complement
      fmt[sign_bit] = sample[sign_bit] ^ cfg.dfmt_type;
      if (cfg.sign_extend) begin
        fmt[sample_width-1:converter_bits] = {(sample_width-converter_bits){fmt[sign_bit]}};
      end else begin
        fmt[sample_width-1:converter_bits] = '0;
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid && cfg.enable;
    end
  end

  always_ff @(posedge link_clk) begin
    out_sample <= fmt;
  end

endmodule

`default_nettype wire

// File: rtl/tpl_adc.sv
// JESD204 ADC transport layer control and monitor, top level
// register map plus a PN monitor and a data formatter per channel

`default_nettype none

module tpl_adc import tpl_adc_pkg::*; (
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  reg_req_t                req,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output reg_rsp_t                rsp,
  input  logic                    adc_valid,
  input  adc_beat_t               adc_data,
  input  logic                    adc_dovf,
  output logic [num_channels-1:0] out_valid,
  output adc_beat_t               out_data
);

  chan_cfg_t [num_channels-1:0] cfg;
  logic [num_channels-1:0]      pn_err;
  logic [num_channels-1:0]      pn_oos;

  tpl_adc_regmap i_regmap (
    .link_clk  (link_clk),
    .adc_rst   (adc_rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos),
    .adc_dovf  (adc_dovf),
    .cfg       (cfg)
  );

  // ************************************************************
  // per-channel data path
  for (genvar i = 0; i < num_channels; i++) begin : g_channel
    tpl_adc_pn_monitor i_pn_monitor (
      .link_clk (link_clk),
      .adc_rst  (adc_rst),
      .valid    (adc_valid),
      .sample   (adc_data[i]),
      .pn_sel   (cfg[i].pn_sel),
      .pn_err   (pn_err[i]),
      .pn_oos   (pn_oos[i])
    );

    tpl_adc_data_format i_data_format (
      .link_clk   (link_clk),
      .adc_rst    (adc_rst),
      .valid      (adc_valid),
      .sample     (adc_data[i]),
      .cfg        (cfg[i]),
      .out_valid  (out_valid[i]),
      .out_sample (out_data[i])
    );
  end

endmodule

`default_nettype wire

// File: bench/tb_tpl_adc.sv
// Testbench for the ADC transport layer control and monitor block
// register traffic with response stalls, data format, PN monitor and
// overflow checks against reference functions

`default_nettype none

module tb_tpl_adc import tpl_adc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 50;

  logic                    link_clk;
  logic                    adc_rst;
  logic                    req_valid;
  logic                    req_ready;
  reg_req_t                req;
  logic                    rsp_valid;
  logic                    rsp_ready;
  reg_rsp_t                rsp;
  logic                    adc_valid;
  adc_beat_t               adc_data;
  logic                    adc_dovf;
  logic [num_channels-1:0] out_valid;
  adc_beat_t               out_data;

  integer seed = 16;
  int     errors = 0;
  int     tests = 0;

  // register model
  logic [num_channels-1:0][3:0]              ctrl_model = '0;
  logic [num_channels-1:0]                   sticky_model = '0;
  logic [num_channels-1:0]                   oos_model = '1;
  logic                                      ovf_model = 1'b0;
  logic [num_channels-1:0][sample_width-1:0] pn_last;
  pn_seq_e                                   data_seq [num_channels];

  tpl_adc i_tpl_adc (
    .link_clk  (link_clk),
    .adc_rst   (adc_rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .adc_dovf  (adc_dovf),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    link_clk = 1'b0;
    forever #20 link_clk = ~link_clk;
  end

  // ************************************************************
  // reference functions
  // 16 new sequence bits after prev with the newest in bit 0
  function automatic logic [sample_width-1:0] pn_next(input logic [sample_width-1:0] prev,
                                                      input pn_seq_e seq);
    logic [sample_width-1:0] hist;
    int                      tap_hi;
    hist   = prev;
    tap_hi = (seq == pn15) ? 15 : 7;
    for (int k = 0; k < sample_width; k++) begin
      hist = {hist[sample_width-2:0], hist[tap_hi-1] ^ hist[tap_hi-2]};
    end
    return hist;
  endfunction

  // ctrl bit 0 enable, 1 dfmt_type, 2 sign_extend, 3 dfmt_enable
  function automatic logic [15:0] format_ref(input logic [15:0] s, input logic [3:0] ctrl);
    logic [15:0] r;
    r = s;
    if (ctrl[3]) begin
      r[13]    = s[13] ^ ctrl[1];
      r[15:14] = ctrl[2] ? {2{r[13]}} : 2'b00;
    end
    return r;
  endfunction

  function automatic logic [7:0] chan_addr(input int ch, input logic [7:0] offset);
    return chan_base + 8'(ch) * chan_stride + offset;
  endfunction

  function automatic logic [31:0] chan_status_ref(input int ch);
    return {29'd0, oos_model[ch], sticky_model[ch], 1'b0};
  endfunction

  function automatic logic [31:0] common_status_ref();
    return {29'd0, ovf_model, |oos_model, |sticky_model};
  endfunction

  // ************************************************************
  // helpers
  task automatic note_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_run(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $finish;
  endtask

  // one register transaction entered and left just after a rising edge
  task automatic reg_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output reg_rsp_t result);
    int       cyc;
    integer   rnd;
    reg_rsp_t held;
    req_valid <= 1'b1;
    req.write <= wr;
    req.addr  <= addr;
    req.wdata <= wdata;
    cyc = 0;
    @(negedge link_clk);
    while (!req_ready) begin
      if (cyc == timeout_cycles) begin
        abort_run("register port never raised req_ready");
      end
      @(negedge link_clk);
      cyc++;
    end
    // accepting edge
    @(posedge link_clk);
    req_valid <= 1'b0;
    cyc = 0;
    @(negedge link_clk);
    while (!rsp_valid) begin
      if (cyc == timeout_cycles) begin
        abort_run("no response on the register port");
      end
      @(posedge link_clk);
      rnd = $random(seed);
      rsp_ready <= rnd[0];
      cyc++;
      @(negedge link_clk);
    end
    assert (cyc == 2 && !req_ready) else
      note_mismatch($sformatf("rsp_valid after %0d cycles, req_ready %b", cyc, req_ready));
    held = rsp;
    cyc = 0;
    while (!rsp_ready) begin
      if (cyc == timeout_cycles) begin
        abort_run("rsp_ready stall loop did not end");
      end
      @(posedge link_clk);
      rnd = $random(seed);
      rsp_ready <= rnd[0];
      cyc++;
      @(negedge link_clk);
      assert (rsp_valid && rsp == held) else
        note_mismatch("response changed while stalled");
    end
    @(posedge link_clk);
    rsp_ready <= 1'b0;
    result = held;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_rsp_t r;
    reg_transfer(1'b1, addr, data, r);
    assert (!r.err) else
      note_mismatch($sformatf("write to 0x%02h returned err", addr));
  endtask

  task automatic reg_check(input logic [7:0] addr, input logic [31:0] expected);
    reg_rsp_t r;
    reg_transfer(1'b0, addr, 32'd0, r);
    assert (!r.err && r.rdata == expected) else
      note_mismatch($sformatf("read 0x%02h gave %h err %b, expected %h",
                              addr, r.rdata, r.err, expected));
  endtask

  task automatic set_ctrl(input int ch, input logic [3:0] value);
    reg_write(chan_addr(ch, chan_ctrl), 32'(value));
    ctrl_model[ch] = value;
  endtask

  task automatic check_status();
    for (int ch = 0; ch < num_channels; ch++) begin
      reg_check(chan_addr(ch, chan_status), chan_status_ref(ch));
    end
    reg_check(reg_status, common_status_ref());
  endtask

  task automatic send_beat(input adc_beat_t beat);
    adc_valid <= 1'b1;
    adc_data  <= beat;
    @(posedge link_clk);
  endtask

  task automatic go_idle(input int cycles);
    adc_valid <= 1'b0;
    repeat (cycles) @(posedge link_clk);
  endtask

  // corrupt_at below zero keeps the stream clean
  task automatic send_pn(input int count, input int corrupt_at);
    adc_beat_t beat;
    for (int i = 0; i < count; i++) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        pn_last[ch] = pn_next(pn_last[ch], data_seq[ch]);
        beat[ch]    = pn_last[ch];
      end
      if (i == corrupt_at) begin
        beat[0] = beat[0] ^ 16'h0100;
      end
      send_beat(beat);
    end
    go_idle(4);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    end
  endtask

  // ************************************************************
  // output compare one cycle behind each beat
  initial begin : compare_out
    logic [num_channels-1:0] exp_valid;
    adc_beat_t               exp_data;
    exp_valid = '0;
    exp_data  = '0;
    forever begin
      @(negedge link_clk);
      for (int ch = 0; ch < num_channels; ch++) begin
        if (adc_rst === 1'b0) begin
          assert (out_valid[ch] == exp_valid[ch]) else
            note_mismatch($sformatf("channel %0d out_valid %b, expected %b",
                                    ch, out_valid[ch], exp_valid[ch]));
          if (exp_valid[ch]) begin
            assert (out_data[ch] == exp_data[ch]) else
              note_mismatch($sformatf("channel %0d out_data %h, expected %h",
                                      ch, out_data[ch], exp_data[ch]));
          end
        end
        exp_valid[ch] = !adc_rst && adc_valid && ctrl_model[ch][0];
        exp_data[ch]  = format_ref(adc_data[ch], ctrl_model[ch]);
      end
    end
  end

  initial begin : stimulus
    reg_rsp_t    r;
    int          mark;
    logic [31:0] value;
    adc_beat_t   beat;
    adc_rst   <= 1'b1;
    req_valid <= 1'b0;
    req       <= '0;
    rsp_ready <= 1'b0;
    adc_valid <= 1'b0;
    adc_data  <= '0;
    adc_dovf  <= 1'b0;
    repeat (8) @(posedge link_clk);
    adc_rst <= 1'b0;
    @(posedge link_clk);

    mark = errors;
    @(negedge link_clk);
    assert (req_ready && !rsp_valid && out_valid == '0) else
      note_mismatch("register port or out_valid not idle after reset");
    @(posedge link_clk);
    reg_check(reg_version, core_version);
    reg_check(reg_clk_ratio, 32'd1);
    reg_check(reg_status, common_status_ref());
    end_test("reset state", mark);

    mark = errors;
    for (int i = 0; i < 4; i++) begin
      value = $random(seed);
      reg_write(reg_scratch, value);
      reg_check(reg_scratch, value);
    end
    reg_transfer(1'b0, 8'h05, 32'd0, r);
    assert (r.err && r.rdata == '0) else
      note_mismatch($sformatf("unmapped read gave %h err %b", r.rdata, r.err));
    reg_transfer(1'b0, chan_addr(1, 8'h03), 32'd0, r);
    assert (r.err && r.rdata == '0) else
      note_mismatch($sformatf("unmapped channel read gave %h err %b", r.rdata, r.err));
    end_test("scratch and handshake", mark);

    // channel 1 gets the opposite enable and sign_extend
    mark = errors;
    for (int c = 0; c < 16; c++) begin
      set_ctrl(0, 4'(c));
      set_ctrl(1, 4'(c) ^ 4'b0101);
      for (int b = 0; b < 6; b++) begin
        beat = $random(seed);
        send_beat(beat);
      end
      go_idle(2);
    end
    set_ctrl(0, 4'd0);
    set_ctrl(1, 4'd0);
    end_test("data format", mark);

    mark = errors;
    data_seq[0] = pn7;
    data_seq[1] = pn15;
    pn_last[0]  = 16'h1234;
    pn_last[1]  = 16'hace1;
    reg_write(chan_addr(0, chan_pn_sel), 32'(pn7));
    reg_write(chan_addr(1, chan_pn_sel), 32'(pn15));
    send_pn(24, -1);
    oos_model = '0;
    check_status();
    send_pn(8, 3);
    sticky_model[0] = 1'b1;
    check_status();
    reg_write(chan_addr(0, chan_status), 32'h2);
    sticky_model[0] = 1'b0;
    check_status();
    end_test("pn sync and sticky error", mark);

    // wrong sequence flags errors until sync is lost
    mark = errors;
    reg_write(chan_addr(0, chan_pn_sel), 32'(pn15));
    reg_write(chan_addr(1, chan_pn_sel), 32'(pn7));
    send_pn(12, -1);
    oos_model    = '1;
    sticky_model = '1;
    check_status();
    for (int ch = 0; ch < num_channels; ch++) begin
      reg_write(chan_addr(ch, chan_status), 32'h2);
    end
    sticky_model = '0;
    reg_write(chan_addr(0, chan_pn_sel), 32'(pn7));
    reg_write(chan_addr(1, chan_pn_sel), 32'(pn15));
    send_pn(24, -1);
    oos_model = '0;
    check_status();
    end_test("pn loss of sync", mark);

    mark = errors;
    adc_dovf <= 1'b1;
    @(posedge link_clk);
    adc_dovf <= 1'b0;
    go_idle(2);
    ovf_model = 1'b1;
    check_status();
    reg_check(reg_status, common_status_ref());
    reg_write(reg_status, 32'h4);
    ovf_model = 1'b0;
    reg_check(reg_status, common_status_ref());
    end_test("sticky overflow", mark);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
rtl/tpl_adc_pkg.sv
rtl/tpl_adc_regmap_common.sv
rtl/tpl_adc_regmap_channel.sv
rtl/tpl_adc_regmap.sv
rtl/tpl_adc_pn_monitor.sv
rtl/tpl_adc_data_format.sv
rtl/tpl_adc.sv
bench/tb_tpl_adc.sv
